// File: src/tp_defs.svh
`ifndef TP_DEFS_SVH
`define TP_DEFS_SVH

// engine geometry
`define TP_VECTOR_SIZE   5
`define TP_CELL_WIDTH    8
`define TP_TILING_H      4  // products per result word
`define TP_WORD_WIDTH    (`TP_TILING_H * 2 * `TP_CELL_WIDTH)
`define TP_TILES_PER_ROW ((`TP_VECTOR_SIZE + `TP_TILING_H - 1) / `TP_TILING_H)

// scratch memory
`define TP_MEM_DEPTH     16
`define TP_ADDR_WIDTH    4
`define TP_A_ADDR        0  // operand a, cells packed from bit 0
`define TP_B_ADDR        1
`define TP_RES_BASE      2  // row i, tile h at base + i*tiles + h

// apb byte offsets
`define TP_APB_CTRL      12'h000
`define TP_APB_STATUS    12'h004
`define TP_APB_MEM_BASE  12'h100  // word w, half k at base + 8w + 4k

`endif

// File: src/tp_pkg.sv
`include "tp_defs.svh"

package tp_pkg;

    // one memory access, held until gnt
    typedef struct packed {
        logic                      valid;
        logic                      we;
        logic [`TP_ADDR_WIDTH-1:0] addr;
        logic [1:0]                wstrb;  // one bit per 32-bit half
        logic [`TP_WORD_WIDTH-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                      gnt;     // request taken this cycle
        logic                      rvalid;  // one cycle after a granted read
        logic [`TP_WORD_WIDTH-1:0] rdata;
    } mem_rsp_t;

    // engine state as seen by software
    typedef struct packed {
        logic busy;
        logic done;
    } engine_status_t;

endpackage

// File: src/tp_scratch_mem.sv
`include "tp_defs.svh"

module tp_scratch_mem (
    input  logic             clk,
    input  tp_pkg::mem_req_t req,
    output tp_pkg::mem_rsp_t rsp
);

    localparam int WW = `TP_WORD_WIDTH;

    logic [WW-1:0] mem [`TP_MEM_DEPTH];
    logic [WW-1:0] rdata_q;
    logic          rvalid_q;

    // half-word writes
    always_ff @(posedge clk) begin
        if (req.valid && req.we) begin
            for (int k = 0; k < 2; k++) begin
                if (req.wstrb[k]) begin
                    mem[req.addr][k*32 +: 32] <= req.wdata[k*32 +: 32];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        rvalid_q <= req.valid && !req.we;
        if (req.valid && !req.we) begin
            rdata_q <= mem[req.addr];
        end
    end

    // single port, never stalls
    assign rsp.gnt    = req.valid;
    assign rsp.rvalid = rvalid_q;
    assign rsp.rdata  = rdata_q;

endmodule

// File: src/tp_mem_arbiter.sv
module tp_mem_arbiter (
    input  logic             clk,
    input  logic             rst,
    input  tp_pkg::mem_req_t req_a,
    input  tp_pkg::mem_req_t req_b,
    input  tp_pkg::mem_rsp_t mem_rsp,
    output tp_pkg::mem_rsp_t rsp_a,
    output tp_pkg::mem_rsp_t rsp_b,
    output tp_pkg::mem_req_t mem_req
);

    logic prio_b;      // b wins the next tie
    logic sel_b;       // b owns the memory this cycle
    logic rd_owner_b;  // issuer of the last granted read

    always_comb begin
        if (req_a.valid && req_b.valid) begin
            sel_b = prio_b;
        end else begin
            sel_b = req_b.valid;
        end
    end

    assign mem_req = sel_b ? req_b : req_a;

    always_ff @(posedge clk) begin
        if (rst) begin
            prio_b     <= 1'b0;
            rd_owner_b <= 1'b0;
        end else if (mem_rsp.gnt) begin
            prio_b <= !sel_b;  // loser goes first next time
            if (!mem_req.we) begin
                rd_owner_b <= sel_b;
            end
        end
    end

    // read data returns to whoever issued the read a cycle ago
    always_comb begin
        rsp_a.gnt    = mem_rsp.gnt && !sel_b;
        rsp_a.rvalid = mem_rsp.rvalid && !rd_owner_b;
        rsp_a.rdata  = mem_rsp.rdata;
        rsp_b.gnt    = mem_rsp.gnt && sel_b;
        rsp_b.rvalid = mem_rsp.rvalid && rd_owner_b;
        rsp_b.rdata  = mem_rsp.rdata;
    end

endmodule

// File: src/outer_product_engine.sv
`include "tp_defs.svh"

module outer_product_engine (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  tp_pkg::mem_rsp_t       mem_rsp,
    output tp_pkg::mem_req_t       mem_req,
    output tp_pkg::engine_status_t status
);

    localparam int CW     = `TP_CELL_WIDTH;
    localparam int TH     = `TP_TILING_H;
    localparam int VS     = `TP_VECTOR_SIZE;
    localparam int TILES  = `TP_TILES_PER_ROW;
    localparam int AW     = `TP_ADDR_WIDTH;
    localparam int ROW_W  = (VS > 1) ? $clog2(VS) : 1;
    localparam int TILE_W = (TILES > 1) ? $clog2(TILES) : 1;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH_A,
        ST_FETCH_B,
        ST_COMPUTE,
        ST_DONE
    } state_t;

    state_t                    state;
    logic                      rd_wait;  // read granted, data not back yet
    logic                      done_q;
    logic [ROW_W-1:0]          row_q;
    logic [TILE_W-1:0]         tile_q;
    logic [`TP_WORD_WIDTH-1:0] a_q;
    logic [`TP_WORD_WIDTH-1:0] b_q;
    logic [CW-1:0]             a_cell;
    logic [CW-1:0]             b_cell [TILES*TH];
    logic [TH*2*CW-1:0]        tile_product;
    logic [AW-1:0]             res_addr;
    logic                      last_tile;
    logic                      last_row;

    assign a_cell = a_q[row_q*CW +: CW];

    // b cells past the vector end read as zero
    for (genvar g = 0; g < TILES*TH; g++) begin : g_b_cell
        if (g < VS) begin : g_used
            assign b_cell[g] = b_q[g*CW +: CW];
        end else begin : g_pad
            assign b_cell[g] = '0;
        end
    end

    for (genvar j = 0; j < TH; j++) begin : g_lane
        assign tile_product[j*2*CW +: 2*CW] = a_cell * b_cell[tile_q*TH + j];
    end

    assign res_addr  = AW'(`TP_RES_BASE + row_q * TILES + tile_q);
    assign last_tile = (tile_q == TILE_W'(TILES - 1));
    assign last_row  = (row_q == ROW_W'(VS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ST_IDLE;
            rd_wait <= 1'b0;
            done_q  <= 1'b0;
            row_q   <= '0;
            tile_q  <= '0;
        end else begin
            case (state)
                ST_IDLE, ST_DONE: begin
                    if (start) begin
                        state  <= ST_FETCH_A;
                        done_q <= 1'b0;
                        row_q  <= '0;
                        tile_q <= '0;
                    end else begin
                        state <= ST_IDLE;
                    end
                end
                ST_FETCH_A: begin
                    if (mem_rsp.gnt) rd_wait <= 1'b1;
                    if (mem_rsp.rvalid) begin
                        rd_wait <= 1'b0;
                        state   <= ST_FETCH_B;
                    end
                end
                ST_FETCH_B: begin
                    if (mem_rsp.gnt) rd_wait <= 1'b1;
                    if (mem_rsp.rvalid) begin
                        rd_wait <= 1'b0;
                        state   <= ST_COMPUTE;
                    end
                end
                ST_COMPUTE: begin
                    if (mem_rsp.gnt) begin  // counters move only on an accepted write
                        if (!last_tile) begin
                            tile_q <= tile_q + 1'b1;
                        end else begin
                            tile_q <= '0;
                            if (last_row) begin
                                state  <= ST_DONE;
                                done_q <= 1'b1;
                            end else begin
                                row_q <= row_q + 1'b1;
                            end
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // operand words
    always_ff @(posedge clk) begin
        if (mem_rsp.rvalid && state == ST_FETCH_A) a_q <= mem_rsp.rdata;
        if (mem_rsp.rvalid && state == ST_FETCH_B) b_q <= mem_rsp.rdata;
    end

    always_comb begin
        mem_req       = '0;
        mem_req.wdata = tile_product;
        case (state)
            ST_FETCH_A: begin
                mem_req.valid = !rd_wait;
                mem_req.addr  = AW'(`TP_A_ADDR);
            end
            ST_FETCH_B: begin
                mem_req.valid = !rd_wait;
                mem_req.addr  = AW'(`TP_B_ADDR);
            end
            ST_COMPUTE: begin
                mem_req.valid = 1'b1;
                mem_req.we    = 1'b1;
                mem_req.addr  = res_addr;
                mem_req.wstrb = 2'b11;  // full tile per word
            end
            default: mem_req.valid = 1'b0;
        endcase
    end

    assign status.busy = (state == ST_FETCH_A) || (state == ST_FETCH_B) ||
                         (state == ST_COMPUTE);
    assign status.done = done_q;

endmodule

// File: src/tp_apb_regs.sv
`include "tp_defs.svh"

module tp_apb_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [11:0]            paddr,
    input  logic [31:0]            pwdata,
    input  tp_pkg::engine_status_t status,
    input  tp_pkg::mem_rsp_t       mem_rsp,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic                   start,
    output tp_pkg::mem_req_t       mem_req
);

    localparam int          AW       = `TP_ADDR_WIDTH;
    localparam logic [11:0] WIN_SIZE = 12'(8 * `TP_MEM_DEPTH);

    logic        access;
    logic        ctrl_hit;
    logic        status_hit;
    logic        win_hit;
    logic [11:0] win_off;   // byte offset inside the memory window
    logic        err;
    logic        win_ready;
    logic        rd_wait;
    logic [31:0] rdata_half;

    assign access     = psel && penable;
    assign ctrl_hit   = (paddr == `TP_APB_CTRL);
    assign status_hit = (paddr == `TP_APB_STATUS);
    assign win_off    = paddr - `TP_APB_MEM_BASE;
    assign win_hit    = (paddr >= `TP_APB_MEM_BASE) && (win_off < WIN_SIZE);

    // unmapped offset or write to a read-only register
    assign err = !(ctrl_hit || status_hit || win_hit) || (status_hit && pwrite);

    // writes finish on gnt, reads when the data comes back
    assign win_ready = pwrite ? mem_rsp.gnt : mem_rsp.rvalid;
    assign pready    = access && (win_hit ? win_ready : 1'b1);
    assign pslverr   = access && err;

    always_comb begin
        mem_req.valid = access && win_hit && (pwrite || !rd_wait);
        mem_req.we    = pwrite;
        mem_req.addr  = win_off[3 +: AW];
        mem_req.wstrb = pwrite ? (win_off[2] ? 2'b10 : 2'b01) : 2'b00;
        mem_req.wdata = {pwdata, pwdata};  // strobe picks the half
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_wait <= 1'b0;
        end else if (mem_rsp.rvalid) begin
            rd_wait <= 1'b0;
        end else if (mem_rsp.gnt && !pwrite) begin
            rd_wait <= 1'b1;
        end
    end

    // one-cycle start pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            start <= 1'b0;
        end else begin
            start <= access && ctrl_hit && pwrite && pwdata[0];
        end
    end

    assign rdata_half = win_off[2] ? mem_rsp.rdata[63:32] : mem_rsp.rdata[31:0];

    always_comb begin
        prdata = '0;  // ctrl has no readable bits
        if (status_hit) begin
            prdata = {30'b0, status.done, status.busy};
        end else if (win_hit) begin
            prdata = rdata_half;
        end
    end

endmodule

// File: src/tp_top.sv
module tp_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    import tp_pkg::*;

    mem_req_t       eng_req;
    mem_rsp_t       eng_rsp;
    mem_req_t       apb_req;
    mem_rsp_t       apb_rsp;
    mem_req_t       mem_req;
    mem_rsp_t       mem_rsp;
    engine_status_t eng_status;
    logic           start;

    tp_apb_regs u_regs (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .status  (eng_status),
        .mem_rsp (apb_rsp),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .start   (start),
        .mem_req (apb_req)
    );

    outer_product_engine u_engine (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .mem_rsp (eng_rsp),
        .mem_req (eng_req),
        .status  (eng_status)
    );

    // engine on port a, software on port b
    tp_mem_arbiter u_arb (
        .clk     (clk),
        .rst     (rst),
        .req_a   (eng_req),
        .req_b   (apb_req),
        .mem_rsp (mem_rsp),
        .rsp_a   (eng_rsp),
        .rsp_b   (apb_rsp),
        .mem_req (mem_req)
    );

    tp_scratch_mem u_mem (
        .clk (clk),
        .req (mem_req),
        .rsp (mem_rsp)
    );

endmodule

// File: tests/tb_tp_top.sv
`include "tp_defs.svh"

module tb_tp_top;

    localparam int CLK_PERIOD  = 100;
    localparam int NUM_TESTS   = 6;
    localparam int TEST_CYCLES = 2000;  // worst case per test with polling
    localparam int MAX_WAIT    = 50;    // access cycles before a transfer is given up
    localparam int MAX_POLLS   = 100;
    localparam int VS          = `TP_VECTOR_SIZE;
    localparam int TH          = `TP_TILING_H;
    localparam int TILES       = `TP_TILES_PER_ROW;
    localparam int CW          = `TP_CELL_WIDTH;
    localparam int NUM_RES     = VS * TILES;

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    integer      seed = 32'h465ef4c6;
    int          errors;  // failed checks in the running test
    int          tests_passed;
    int          tests_failed;
    logic [63:0] exp_res [NUM_RES];

    tp_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    // outputs sampled a quarter period after the falling edge
    task automatic apb_transfer(input logic write, input logic [11:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        int waited;
        waited = 0;
        rdata  = '0;
        err    = 1'b0;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #(CLK_PERIOD / 4);
        while (!pready && waited < MAX_WAIT) begin
            @(negedge clk);
            #(CLK_PERIOD / 4);
            waited++;
        end
        if (pready) begin
            rdata = prdata;
            err   = pslverr;
        end else begin
            $display("APB transfer to offset 0x%h never completed", addr);
            errors++;
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                             output logic [31:0] rdata, output logic err);
        apb_transfer(1'b1, addr, data, rdata, err);
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] rdata,
                            output logic err);
        apb_transfer(1'b0, addr, 32'h0, rdata, err);
    endtask

    function automatic logic [11:0] win_addr(input int word, input int half);
        return 12'(`TP_APB_MEM_BASE + 8 * word + 4 * half);
    endfunction

    task automatic write_half(input int word, input int half, input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        apb_write(win_addr(word, half), data, rd, err);
        check("pslverr", err, 0);
    endtask

    task automatic read_word(input int word, output logic [63:0] data);
        logic [31:0] lo;
        logic [31:0] hi;
        logic        err;
        apb_read(win_addr(word, 0), lo, err);
        check("pslverr", err, 0);
        apb_read(win_addr(word, 1), hi, err);
        check("pslverr", err, 0);
        data = {hi, lo};
    endtask

    // lane j of row i and tile h holds a[i] * b[h*TH + j] or zero past the vector end
    task automatic compute_expected(input logic [63:0] a_word, input logic [63:0] b_word);
        int idx;
        for (int i = 0; i < VS; i++) begin
            for (int h = 0; h < TILES; h++) begin
                exp_res[i*TILES + h] = '0;
                for (int j = 0; j < TH; j++) begin
                    idx = h * TH + j;
                    if (idx < VS) begin
                        exp_res[i*TILES + h][2*CW*j +: 2*CW] =
                            a_word[CW*i +: CW] * b_word[CW*idx +: CW];
                    end
                end
            end
        end
    endtask

    task automatic load_operands(input logic [63:0] a_word, input logic [63:0] b_word);
        write_half(`TP_A_ADDR, 0, a_word[31:0]);
        write_half(`TP_A_ADDR, 1, a_word[63:32]);
        write_half(`TP_B_ADDR, 0, b_word[31:0]);
        write_half(`TP_B_ADDR, 1, b_word[63:32]);
        compute_expected(a_word, b_word);
    endtask

    task automatic start_engine(input logic [31:0] exp_status);
        logic [31:0] rd;
        logic        err;
        apb_write(`TP_APB_CTRL, 32'h1, rd, err);
        check("pslverr", err, 0);
        apb_read(`TP_APB_STATUS, rd, err);
        check("status", rd, exp_status);  // busy set and done cleared
    endtask

    task automatic wait_done_and_check();
        logic [31:0] st;
        logic [63:0] got;
        logic        err;
        int          polls;
        polls = 0;
        st    = '0;
        while (st[1] !== 1'b1 && polls < MAX_POLLS) begin
            apb_read(`TP_APB_STATUS, st, err);
            polls++;
        end
        if (st[1] !== 1'b1) begin
            $display("engine did not report done after %0d status reads", polls);
            errors++;
        end
        check("status", st, 32'h2);
        for (int r = 0; r < NUM_RES; r++) begin
            read_word(`TP_RES_BASE + r, got);
            check($sformatf("result[%0d]", r), got, exp_res[r]);
        end
    endtask

    task automatic finish_test(input string name);
        if (errors == 0) begin
            $display("%s: passed", name);
            tests_passed++;
        end else begin
            $display("%s: failed with %0d errors", name, errors);
            tests_failed++;
        end
        errors = 0;
    endtask

    task automatic test_reset_state();
        logic [31:0] rd;
        logic        err;
        apb_read(`TP_APB_STATUS, rd, err);
        check("status", rd, 0);
        check("pslverr", err, 0);
        apb_read(`TP_APB_CTRL, rd, err);
        check("ctrl", rd, 0);
        check("pslverr", err, 0);
    endtask

    task automatic test_mem_window();
        logic [63:0] data [12:15];
        logic [63:0] got;
        logic [31:0] fresh;
        for (int w = 12; w < 16; w++) begin
            data[w] = {$random(seed), $random(seed)};
            write_half(w, 0, data[w][31:0]);
            write_half(w, 1, data[w][63:32]);
            read_word(w, got);
            check($sformatf("mem[%0d]", w), got, data[w]);
        end
        for (int w = 12; w < 16; w++) begin  // rewrite one half and keep the other
            fresh = $random(seed);
            write_half(w, w % 2, fresh);
            data[w][32*(w%2) +: 32] = fresh;
            read_word(w, got);
            check($sformatf("mem[%0d]", w), got, data[w]);
        end
    endtask

    task automatic test_directed();
        load_operands(64'h00000005_04030201, 64'h00000005_040302ff);
        start_engine(32'h1);
        wait_done_and_check();
    endtask

    task automatic test_random_runs();
        repeat (4) begin
            load_operands({$random(seed), $random(seed)}, {$random(seed), $random(seed)});
            start_engine(32'h1);
            wait_done_and_check();
        end
    endtask

    task automatic test_concurrent_reads();
        logic [63:0] a_word;
        logic [63:0] b_word;
        logic [63:0] got;
        a_word = {$random(seed), $random(seed)};
        b_word = {$random(seed), $random(seed)};
        load_operands(a_word, b_word);
        start_engine(32'h1);
        repeat (3) begin  // software competes with the engine here
            read_word(`TP_A_ADDR, got);
            check("operand a", got, a_word);
            read_word(`TP_B_ADDR, got);
            check("operand b", got, b_word);
        end
        wait_done_and_check();
    endtask

    task automatic test_errors();
        logic [31:0] rd;
        logic        err;
        logic [63:0] a_word;
        apb_read(12'h080, rd, err);
        check("pslverr", err, 1);
        apb_write(12'h200, 32'hdead_beef, rd, err);
        check("pslverr", err, 1);
        apb_write(`TP_APB_STATUS, 32'h3, rd, err);
        check("pslverr", err, 1);
        a_word = {$random(seed), $random(seed)};
        load_operands(a_word, {$random(seed), $random(seed)});
        start_engine(32'h1);
        write_half(`TP_A_ADDR, 0, ~a_word[31:0]);  // engine already holds the old a
        start_engine(32'h1);  // ignored while busy
        wait_done_and_check();
    endtask

    initial begin
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        test_reset_state();
        finish_test("reset state");
        test_mem_window();
        finish_test("memory window");
        test_directed();
        finish_test("directed product");
        test_random_runs();
        finish_test("random products");
        test_concurrent_reads();
        finish_test("concurrent reads");
        test_errors();
        finish_test("error responses");
        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(CLK_PERIOD * (5 + NUM_TESTS * TEST_CYCLES));
        $display("timeout: the tests did not finish in the expected time");
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: compile.f
+incdir+src
src/tp_pkg.sv
src/tp_scratch_mem.sv
src/tp_mem_arbiter.sv
src/outer_product_engine.sv
src/tp_apb_regs.sv
src/tp_top.sv
tests/tb_tp_top.sv

// File: Bender.yml
package:
  name: tp_accel

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/tp_pkg.sv
      - src/tp_scratch_mem.sv
      - src/tp_mem_arbiter.sv
      - src/outer_product_engine.sv
      - src/tp_apb_regs.sv
      - src/tp_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/tb_tp_top.sv
